// File: verilog.f
+incdir+hdl
hdl/mesh_pkg.sv
hdl/mesh_ingress.sv
hdl/mesh_tile.sv
hdl/mesh_tile_array.sv
hdl/mesh_egress.sv
hdl/mesh_subarray_top.sv
dv/mesh_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0 -Wno-fatal
TOP       = mesh_tb
FILELIST  = verilog.f
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: dv/mesh_tb.sv
// testbench for the mesh subarray with host driver, responder, reference model and checks
`timescale 1ns/100ps
`include "mesh_params.svh"

module mesh_tb;

  localparam int n_tiles    = `MESH_X * `MESH_Y;
  localparam int n_bad      = 4;
  localparam int n_bp_ops   = 40;
  localparam int n_rand_ops = 300;
  // zero reads, write/read pairs, bad packets with traffic, back-pressure, random mix
  localparam int n_ops = n_tiles * `MESH_MEM_WORDS + 2 * n_tiles + 3 * n_bad +
                         n_bp_ops + n_rand_ops;
  localparam int cycle_limit = 200 * n_ops + 500;

  logic                 clk_i;
  logic                 rst_i;
  mesh_pkg::x_cord_t    origin_x_i;
  mesh_pkg::y_cord_t    origin_y_i;
  mesh_pkg::mesh_link_s req_link_i;
  logic                 req_ack_o;
  mesh_pkg::mesh_link_s resp_link_o;
  logic                 resp_ack_i;
  logic [15:0]          drop_count_o;

  integer            seed;
  integer            resp_seed;
  int                value_errs;
  int                other_errs;
  int                cycles;
  logic [15:0]       exp_drops;
  mesh_pkg::x_cord_t ox;
  mesh_pkg::y_cord_t oy;

  // reference scratch per tile and expected responses per tile, tile = row * MESH_X + col
  mesh_pkg::mesh_data_t model_mem [n_tiles][`MESH_MEM_WORDS];
  mesh_pkg::mesh_pkt_s  exp_q [n_tiles][$];

  mesh_subarray_top i_mesh_subarray_top (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .origin_x_i   (origin_x_i),
    .origin_y_i   (origin_y_i),
    .req_link_i   (req_link_i),
    .req_ack_o    (req_ack_o),
    .resp_link_o  (resp_link_o),
    .resp_ack_i   (resp_ack_i),
    .drop_count_o (drop_count_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic string format_pkt(input mesh_pkg::mesh_pkt_s p);
    return $sformatf("op=%0d x=%0d y=%0d addr=%0d data=%h", p.op, p.dest_x, p.dest_y,
                     p.addr, p.data);
  endfunction

  function automatic int pending_reads();
    int n;
    n = 0;
    for (int t = 0; t < n_tiles; t++) begin
      n += exp_q[t].size();
    end
    return n;
  endfunction

  task automatic report_counts();
    $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
  endtask

  task automatic clear_model();
    for (int t = 0; t < n_tiles; t++) begin
      for (int a = 0; a < `MESH_MEM_WORDS; a++) begin
        model_mem[t][a] = '0;
      end
      exp_q[t].delete();
    end
  endtask

  task automatic apply_reset(input mesh_pkg::x_cord_t new_ox, input mesh_pkg::y_cord_t new_oy);
    @(posedge clk_i);
    rst_i      <= 1'b1;
    origin_x_i <= new_ox;
    origin_y_i <= new_oy;
    ox         = new_ox;
    oy         = new_oy;
    exp_drops  = '0;
    clear_model();
    repeat (10) @(posedge clk_i);
    rst_i <= 1'b0;
  endtask

  // four-phase request handshake on the host port
  task automatic send_pkt(input mesh_pkg::mesh_pkt_s pkt);
    @(posedge clk_i);
    req_link_i <= '{req: 1'b1, pkt: pkt};
    @(posedge clk_i);
    while (!req_ack_o) @(posedge clk_i);
    req_link_i.req <= 1'b0;
    @(posedge clk_i);
    while (req_ack_o) @(posedge clk_i);
  endtask

  task automatic issue_op(input mesh_pkg::mesh_op_e op, input int tile,
                          input mesh_pkg::mem_addr_t addr, input mesh_pkg::mesh_data_t data);
    mesh_pkg::mesh_pkt_s pkt;
    mesh_pkg::mesh_pkt_s exp;
    pkt.op     = op;
    pkt.dest_x = ox + mesh_pkg::x_cord_t'(tile % `MESH_X);
    pkt.dest_y = oy + mesh_pkg::y_cord_t'(tile / `MESH_X);
    pkt.addr   = addr;
    pkt.data   = data;
    if (op == mesh_pkg::op_write) begin
      model_mem[tile][addr] = data;
    end else begin
      // response names the source tile, which is the read's destination
      exp      = pkt;
      exp.op   = mesh_pkg::op_resp;
      exp.data = model_mem[tile][addr];
      exp_q[tile].push_back(exp);
    end
    send_pkt(pkt);
  endtask

  task automatic issue_random(input int read_pct);
    logic [31:0]        rnd;
    logic [31:0]        rnd_data;
    mesh_pkg::mesh_op_e op;
    rnd      = $random(seed);
    rnd_data = $random(seed);
    if (int'(rnd[6:0]) % 100 < read_pct) begin
      op = mesh_pkg::op_read;
    end else begin
      op = mesh_pkg::op_write;
    end
    issue_op(op, int'(rnd[15:8]) % n_tiles, mesh_pkg::mem_addr_t'(rnd[23:16]),
             mesh_pkg::mesh_data_t'(rnd_data[31:16]));
  endtask

  // one coordinate lands 2..15 past the origin, outside the grid
  task automatic issue_bad();
    logic [31:0]         rnd;
    mesh_pkg::mesh_pkt_s pkt;
    int                  off;
    rnd = $random(seed);
    off = 2 + int'(rnd[11:8]) % 14;
    pkt.op   = rnd[0] ? mesh_pkg::op_read : mesh_pkg::op_write;
    pkt.addr = mesh_pkg::mem_addr_t'(rnd[15:12]);
    pkt.data = mesh_pkg::mesh_data_t'(rnd[31:16]);
    if (rnd[1]) begin
      pkt.dest_x = ox + mesh_pkg::x_cord_t'(off);
      pkt.dest_y = oy + mesh_pkg::y_cord_t'(rnd[2]);
    end else begin
      pkt.dest_x = ox + mesh_pkg::x_cord_t'(rnd[2]);
      pkt.dest_y = oy + mesh_pkg::y_cord_t'(off);
    end
    exp_drops = exp_drops + 16'd1;
    send_pkt(pkt);
  endtask

  task automatic compare_pkt(input mesh_pkg::mesh_pkt_s act);
    mesh_pkg::mesh_pkt_s exp;
    mesh_pkg::x_cord_t   dx;
    mesh_pkg::y_cord_t   dy;
    int                  tile;
    dx = act.dest_x - ox;
    dy = act.dest_y - oy;
    if (int'(dx) >= `MESH_X || int'(dy) >= `MESH_Y) begin
      $display("%0t: response names tile (%0d,%0d), which is outside the array",
               $time, act.dest_x, act.dest_y);
      other_errs++;
    end else begin
      tile = int'(dy) * `MESH_X + int'(dx);
      if (exp_q[tile].size() == 0) begin
        $display("%0t: response from tile (%0d,%0d) arrived with no read outstanding",
                 $time, act.dest_x, act.dest_y);
        other_errs++;
      end else begin
        exp = exp_q[tile].pop_front();
        if (act !== exp) begin
          $display("ERR %0t resp_link_o.pkt expected %s actual %s", $time,
                   format_pkt(exp), format_pkt(act));
          value_errs++;
        end
      end
    end
  endtask

  task automatic compare_count(input logic [15:0] exp, input logic [15:0] act);
    if (act !== exp) begin
      $display("ERR %0t drop_count_o expected %0d actual %0d", $time, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_queues_empty();
    for (int t = 0; t < n_tiles; t++) begin
      if (exp_q[t].size() != 0) begin
        $display("%0t: %0d read responses from tile %0d never arrived",
                 $time, exp_q[t].size(), t);
        other_errs++;
      end
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (pending_reads() != 0 && waited < 2000) begin
      @(posedge clk_i);
      waited++;
    end
    // room for the last host handshake and any stray response
    repeat (50) @(posedge clk_i);
  endtask

  // host response side with random ack delay
  initial begin
    int unsigned delay;
    logic [31:0] rnd;
    forever begin
      @(posedge clk_i);
      if (resp_link_o.req && !resp_ack_i) begin
        rnd   = $random(resp_seed);
        delay = rnd % 6;
        repeat (delay) @(posedge clk_i);
        compare_pkt(resp_link_o.pkt);
        resp_ack_i <= 1'b1;
        @(posedge clk_i);
        while (resp_link_o.req) @(posedge clk_i);
        resp_ack_i <= 1'b0;
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout after %0d cycles, traffic stopped moving", cycles);
    report_counts();
    $display("Simulation failed");
    $finish;
  end

  initial begin
    logic [31:0] rnd;
    seed       = 32'hb94ba04c;
    resp_seed  = 32'hb94ba04c;
    value_errs = 0;
    other_errs = 0;
    rst_i      = 1'b1;
    origin_x_i = '0;
    origin_y_i = '0;
    req_link_i = '0;
    resp_ack_i = 1'b0;
    apply_reset('0, '0);

    // every word of every tile reads zero after reset
    for (int t = 0; t < n_tiles; t++) begin
      for (int a = 0; a < `MESH_MEM_WORDS; a++) begin
        issue_op(mesh_pkg::op_read, t, mesh_pkg::mem_addr_t'(a), '0);
      end
    end

    // write then read back on each tile
    for (int t = 0; t < n_tiles; t++) begin
      rnd = $random(seed);
      issue_op(mesh_pkg::op_write, t, mesh_pkg::mem_addr_t'(rnd[7:0]),
               mesh_pkg::mesh_data_t'(rnd[31:16]));
      issue_op(mesh_pkg::op_read, t, mesh_pkg::mem_addr_t'(rnd[7:0]), '0);
    end

    // bad destinations mixed into valid traffic
    for (int i = 0; i < n_bad; i++) begin
      issue_bad();
      issue_random(50);
      issue_random(50);
    end

    // read-heavy burst against the slow responder
    for (int i = 0; i < n_bp_ops; i++) begin
      issue_random(80);
    end
    wait_drain();
    check_queues_empty();
    compare_count(exp_drops, drop_count_o);

    // nonzero origin and a long random mix
    apply_reset(mesh_pkg::x_cord_t'(3), mesh_pkg::y_cord_t'(5));
    for (int i = 0; i < n_rand_ops; i++) begin
      issue_random(50);
    end
    wait_drain();
    check_queues_empty();
    compare_count(exp_drops, drop_count_o);

    report_counts();
    if (value_errs == 0 && other_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: hdl/mesh_subarray_top.sv
// subarray top level joining ingress, tile array and egress
`timescale 1ns/100ps
`include "mesh_params.svh"

module mesh_subarray_top (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  mesh_pkg::x_cord_t    origin_x_i,
  input  mesh_pkg::y_cord_t    origin_y_i,
  input  mesh_pkg::mesh_link_s req_link_i,
  output logic                 req_ack_o,
  output mesh_pkg::mesh_link_s resp_link_o,
  input  logic                 resp_ack_i,
  output logic [15:0]          drop_count_o
);

  // ingress to tile (0,0)
  mesh_pkg::mesh_link_s               inj_link;
  logic                               inj_ack;
  // east edge rows to egress
  mesh_pkg::mesh_link_s [`MESH_Y-1:0] row_link;
  logic [`MESH_Y-1:0]                 row_ack;

  mesh_ingress i_mesh_ingress (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .origin_x_i   (origin_x_i),
    .origin_y_i   (origin_y_i),
    .host_link_i  (req_link_i),
    .host_ack_o   (req_ack_o),
    .tile_link_o  (inj_link),
    .tile_ack_i   (inj_ack),
    .drop_count_o (drop_count_o)
  );

  mesh_tile_array i_mesh_tile_array (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .origin_x_i (origin_x_i),
    .origin_y_i (origin_y_i),
    .in_link_i  (inj_link),
    .in_ack_o   (inj_ack),
    .out_link_o (row_link),
    .out_ack_i  (row_ack)
  );

  mesh_egress i_mesh_egress (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .row_link_i  (row_link),
    .row_ack_o   (row_ack),
    .host_link_o (resp_link_o),
    .host_ack_i  (resp_ack_i)
  );

endmodule

// File: hdl/mesh_egress.sv
// round-robin merge of east-edge response links onto the host response port
`timescale 1ns/100ps
`include "mesh_params.svh"

module mesh_egress (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  mesh_pkg::mesh_link_s [`MESH_Y-1:0] row_link_i,
  output logic [`MESH_Y-1:0]                 row_ack_o,
  output mesh_pkg::mesh_link_s               host_link_o,
  input  logic                               host_ack_i
);

  mesh_pkg::tile_state_e         state;
  mesh_pkg::mesh_pkt_s           slot;
  logic                          host_req;
  logic [$clog2(`MESH_Y)-1:0]    last_row;
  logic [$clog2(`MESH_Y)-1:0]    sel_row;
  logic [$clog2(`MESH_Y)-1:0]    pick_row;
  logic [`MESH_Y-1:0]            row_req;
  logic                          found;

  // first requester after the last served row, wrapping around
  always_comb begin
    int unsigned idx;
    idx      = 0;
    found    = 1'b0;
    pick_row = last_row;
    for (int i = 0; i < `MESH_Y; i++) begin
      row_req[i] = row_link_i[i].req;
    end
    for (int i = 1; i <= `MESH_Y; i++) begin
      idx = (int'(last_row) + i) % `MESH_Y;
      if (!found && row_req[idx]) begin
        pick_row = idx[$clog2(`MESH_Y)-1:0];
        found    = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state == mesh_pkg::st_idle && found) begin
      slot <= row_link_i[pick_row].pkt;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state     <= mesh_pkg::st_idle;
      row_ack_o <= '0;
      host_req  <= 1'b0;
      last_row  <= '0;
      sel_row   <= '0;
    end else begin
      case (state)
        mesh_pkg::st_idle: begin
          if (found) begin
            row_ack_o[pick_row] <= 1'b1;
            sel_row             <= pick_row;
            last_row            <= pick_row;
            state               <= mesh_pkg::st_recv_ack;
          end
        end
        mesh_pkg::st_recv_ack: begin
          if (!row_req[sel_row]) begin
            row_ack_o <= '0;
            host_req  <= 1'b1;
            state     <= mesh_pkg::st_send;
          end
        end
        mesh_pkg::st_send: begin
          if (host_ack_i) begin
            host_req <= 1'b0;
            state    <= mesh_pkg::st_release;
          end
        end
        mesh_pkg::st_release: begin
          // slow host ack holds every row off
          if (!host_ack_i) begin
            state <= mesh_pkg::st_idle;
          end
        end
        default: state <= mesh_pkg::st_idle;
      endcase
    end
  end

  assign host_link_o = '{req: host_req, pkt: slot};

endmodule

// File: hdl/mesh_tile_array.sv
// tile grid with neighbour link stitching, edge tie-offs and row-0 coordinate seeds
`timescale 1ns/100ps
`include "mesh_params.svh"

module mesh_tile_array (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  mesh_pkg::x_cord_t                   origin_x_i,
  input  mesh_pkg::y_cord_t                   origin_y_i,
  input  mesh_pkg::mesh_link_s                in_link_i,
  output logic                                in_ack_o,
  output mesh_pkg::mesh_link_s [`MESH_Y-1:0]  out_link_o,
  input  logic [`MESH_Y-1:0]                  out_ack_i
);

  // per-tile link and chain signals, indexed [row][col]
  mesh_pkg::mesh_link_s w_link_li [`MESH_Y][`MESH_X];
  mesh_pkg::mesh_link_s n_link_li [`MESH_Y][`MESH_X];
  mesh_pkg::mesh_link_s e_link_lo [`MESH_Y][`MESH_X];
  mesh_pkg::mesh_link_s s_link_lo [`MESH_Y][`MESH_X];
  logic                 w_ack_lo  [`MESH_Y][`MESH_X];
  logic                 n_ack_lo  [`MESH_Y][`MESH_X];
  logic                 e_ack_li  [`MESH_Y][`MESH_X];
  logic                 s_ack_li  [`MESH_Y][`MESH_X];
  logic                 rst_li    [`MESH_Y][`MESH_X];
  logic                 rst_lo    [`MESH_Y][`MESH_X];
  mesh_pkg::x_cord_t    x_li      [`MESH_Y][`MESH_X];
  mesh_pkg::x_cord_t    x_lo      [`MESH_Y][`MESH_X];
  mesh_pkg::y_cord_t    y_li      [`MESH_Y][`MESH_X];
  mesh_pkg::y_cord_t    y_lo      [`MESH_Y][`MESH_X];

  for (genvar r = 0; r < `MESH_Y; r++) begin : g_row
    for (genvar c = 0; c < `MESH_X; c++) begin : g_col
      mesh_tile i_mesh_tile (
        .clk_i    (clk_i),
        .rst_i    (rst_li[r][c]),
        .rst_o    (rst_lo[r][c]),
        .x_i      (x_li[r][c]),
        .y_i      (y_li[r][c]),
        .x_o      (x_lo[r][c]),
        .y_o      (y_lo[r][c]),
        .w_link_i (w_link_li[r][c]),
        .w_ack_o  (w_ack_lo[r][c]),
        .n_link_i (n_link_li[r][c]),
        .n_ack_o  (n_ack_lo[r][c]),
        .e_link_o (e_link_lo[r][c]),
        .e_ack_i  (e_ack_li[r][c]),
        .s_link_o (s_link_lo[r][c]),
        .s_ack_i  (s_ack_li[r][c])
      );

      // west side: ingress into (0,0), idle on the rest of column 0
      if (c == 0) begin : g_w_edge
        if (r == 0) begin : g_inject
          assign w_link_li[r][c] = in_link_i;
          assign in_ack_o        = w_ack_lo[r][c];
        end else begin : g_idle
          assign w_link_li[r][c] = '0;
        end
      end else begin : g_w_nbr
        assign w_link_li[r][c]  = e_link_lo[r][c-1];
        assign e_ack_li[r][c-1] = w_ack_lo[r][c];
      end

      // east edge feeds the egress, one link per row
      if (c == `MESH_X-1) begin : g_e_edge
        assign out_link_o[r]   = e_link_lo[r][c];
        assign e_ack_li[r][c]  = out_ack_i[r];
      end

      // row 0 takes reset and seeds from the top
      if (r == 0) begin : g_n_edge
        assign n_link_li[r][c] = '0;
        assign rst_li[r][c]    = rst_i;
        assign x_li[r][c]      = origin_x_i + mesh_pkg::x_cord_t'(c);
        assign y_li[r][c]      = origin_y_i;
      end else begin : g_n_nbr
        assign n_link_li[r][c]  = s_link_lo[r-1][c];
        assign s_ack_li[r-1][c] = n_ack_lo[r][c];
        assign rst_li[r][c]     = rst_lo[r-1][c];
        assign x_li[r][c]       = x_lo[r-1][c];
        assign y_li[r][c]       = y_lo[r-1][c];
      end

      // bottom row never sends south
      if (r == `MESH_Y-1) begin : g_s_edge
        assign s_ack_li[r][c] = 1'b0;
      end
    end
  end

endmodule

// File: hdl/mesh_tile.sv
// mesh tile with input arbitration, single-slot XY router, scratch memory and reset/coordinate chain
`timescale 1ns/100ps
`include "mesh_params.svh"

module mesh_tile (
  input  logic                 clk_i,
  input  logic                 rst_i,
  output logic                 rst_o,
  input  mesh_pkg::x_cord_t    x_i,
  input  mesh_pkg::y_cord_t    y_i,
  output mesh_pkg::x_cord_t    x_o,
  output mesh_pkg::y_cord_t    y_o,
  input  mesh_pkg::mesh_link_s w_link_i,
  output logic                 w_ack_o,
  input  mesh_pkg::mesh_link_s n_link_i,
  output logic                 n_ack_o,
  output mesh_pkg::mesh_link_s e_link_o,
  input  logic                 e_ack_i,
  output mesh_pkg::mesh_link_s s_link_o,
  input  logic                 s_ack_i
);

  logic                  rst_r;
  mesh_pkg::x_cord_t     x_r;
  mesh_pkg::y_cord_t     y_r;
  mesh_pkg::tile_state_e state;
  mesh_pkg::mesh_pkt_s   slot;
  mesh_pkg::mesh_data_t  mem [`MESH_MEM_WORDS];
  logic                  sel_n;
  logic                  last_n;
  logic                  dir_s;
  logic                  e_req;
  logic                  s_req;
  logic                  pick_n;
  logic                  in_req;
  logic                  sel_req;
  logic                  out_ack;
  logic                  go_east;
  logic                  go_south;
  logic                  is_local;

  // one register per tile down the column
  always_ff @(posedge clk_i) begin
    rst_r <= rst_i;
    x_r   <= x_i;
    y_r   <= y_i;
  end

  assign rst_o = rst_r;
  assign x_o   = x_r;
  assign y_o   = y_r + mesh_pkg::y_cord_t'(1);

  always_comb begin
    // on a tie, serve the side that lost last time
    pick_n   = n_link_i.req & (~w_link_i.req | ~last_n);
    in_req   = w_link_i.req | n_link_i.req;
    sel_req  = sel_n ? n_link_i.req : w_link_i.req;
    out_ack  = dir_s ? s_ack_i : e_ack_i;
    // X first, then Y; responses always head east
    go_east  = (slot.op == mesh_pkg::op_resp) || (slot.dest_x != x_r);
    go_south = !go_east && (slot.dest_y != y_r);
    is_local = !go_east && !go_south;
  end

  always_ff @(posedge clk_i) begin
    if (state == mesh_pkg::st_idle && in_req) begin
      slot <= pick_n ? n_link_i.pkt : w_link_i.pkt;
    end else if (state == mesh_pkg::st_process && is_local && slot.op == mesh_pkg::op_read) begin
      slot.op     <= mesh_pkg::op_resp;
      slot.dest_x <= x_r;
      slot.dest_y <= y_r;
      slot.data   <= mem[slot.addr];
    end
  end

  // scratch words read back as zero after reset
  always_ff @(posedge clk_i) begin
    if (rst_r) begin
      mem <= '{default: '0};
    end else if (state == mesh_pkg::st_process && is_local &&
                 slot.op == mesh_pkg::op_write) begin
      mem[slot.addr] <= slot.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_r) begin
      state   <= mesh_pkg::st_idle;
      w_ack_o <= 1'b0;
      n_ack_o <= 1'b0;
      e_req   <= 1'b0;
      s_req   <= 1'b0;
      sel_n   <= 1'b0;
      last_n  <= 1'b0;
      dir_s   <= 1'b0;
    end else begin
      case (state)
        mesh_pkg::st_idle: begin
          if (in_req) begin
            sel_n   <= pick_n;
            last_n  <= pick_n;
            w_ack_o <= ~pick_n;
            n_ack_o <= pick_n;
            state   <= mesh_pkg::st_recv_ack;
          end
        end
        mesh_pkg::st_recv_ack: begin
          if (!sel_req) begin
            w_ack_o <= 1'b0;
            n_ack_o <= 1'b0;
            state   <= mesh_pkg::st_process;
          end
        end
        mesh_pkg::st_process: begin
          if (go_south) begin
            s_req <= 1'b1;
            dir_s <= 1'b1;
            state <= mesh_pkg::st_send;
          end else if (go_east || slot.op == mesh_pkg::op_read) begin
            // local reads leave east as responses
            e_req <= 1'b1;
            dir_s <= 1'b0;
            state <= mesh_pkg::st_send;
          end else begin
            state <= mesh_pkg::st_idle;
          end
        end
        mesh_pkg::st_send: begin
          if (out_ack) begin
            e_req <= 1'b0;
            s_req <= 1'b0;
            state <= mesh_pkg::st_release;
          end
        end
        mesh_pkg::st_release: begin
          if (!out_ack) begin
            state <= mesh_pkg::st_idle;
          end
        end
        default: state <= mesh_pkg::st_idle;
      endcase
    end
  end

  assign e_link_o = '{req: e_req, pkt: slot};
  assign s_link_o = '{req: s_req, pkt: slot};

endmodule

// File: hdl/mesh_ingress.sv
// host request ingress with destination bounds check, drop counter and tile-side injection
`timescale 1ns/100ps
`include "mesh_params.svh"

module mesh_ingress (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  mesh_pkg::x_cord_t    origin_x_i,
  input  mesh_pkg::y_cord_t    origin_y_i,
  input  mesh_pkg::mesh_link_s host_link_i,
  output logic                 host_ack_o,
  output mesh_pkg::mesh_link_s tile_link_o,
  input  logic                 tile_ack_i,
  output logic [15:0]          drop_count_o
);

  mesh_pkg::tile_state_e state;
  mesh_pkg::mesh_pkt_s   slot;
  logic                  tile_req;
  mesh_pkg::x_cord_t     off_x;
  mesh_pkg::y_cord_t     off_y;
  logic                  dest_ok;

  // offsets wrap below the origin, so one unsigned compare covers both sides
  always_comb begin
    off_x   = slot.dest_x - origin_x_i;
    off_y   = slot.dest_y - origin_y_i;
    dest_ok = (off_x < mesh_pkg::x_cord_t'(`MESH_X)) &&
              (off_y < mesh_pkg::y_cord_t'(`MESH_Y)) &&
              (slot.op != mesh_pkg::op_resp);
  end

  always_ff @(posedge clk_i) begin
    if (state == mesh_pkg::st_idle && host_link_i.req) begin
      slot <= host_link_i.pkt;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state        <= mesh_pkg::st_idle;
      host_ack_o   <= 1'b0;
      tile_req     <= 1'b0;
      drop_count_o <= '0;
    end else begin
      case (state)
        mesh_pkg::st_idle: begin
          if (host_link_i.req) begin
            host_ack_o <= 1'b1;
            state      <= mesh_pkg::st_recv_ack;
          end
        end
        mesh_pkg::st_recv_ack: begin
          if (!host_link_i.req) begin
            host_ack_o <= 1'b0;
            state      <= mesh_pkg::st_process;
          end
        end
        mesh_pkg::st_process: begin
          if (dest_ok) begin
            tile_req <= 1'b1;
            state    <= mesh_pkg::st_send;
          end else begin
            drop_count_o <= drop_count_o + 16'd1;
            state        <= mesh_pkg::st_idle;
          end
        end
        mesh_pkg::st_send: begin
          if (tile_ack_i) begin
            tile_req <= 1'b0;
            state    <= mesh_pkg::st_release;
          end
        end
        mesh_pkg::st_release: begin
          // no new host packet until tile (0,0) drops its ack
          if (!tile_ack_i) begin
            state <= mesh_pkg::st_idle;
          end
        end
        default: state <= mesh_pkg::st_idle;
      endcase
    end
  end

  assign tile_link_o = '{req: tile_req, pkt: slot};

endmodule

// File: hdl/mesh_pkg.sv
// coordinate, address and data typedefs, packet op and tile state enums, packet and link structs
`include "mesh_params.svh"

package mesh_pkg;

  // global tile coordinates
  typedef logic [`MESH_CORD_W-1:0] x_cord_t;
  typedef logic [`MESH_CORD_W-1:0] y_cord_t;

  // scratch word index and data word
  typedef logic [$clog2(`MESH_MEM_WORDS)-1:0] mem_addr_t;
  typedef logic [`MESH_DATA_W-1:0] mesh_data_t;

  typedef enum logic [1:0] {
    op_write = 2'd0,
    op_read  = 2'd1,
    op_resp  = 2'd2
  } mesh_op_e;

  // one slot handshake sequence, shared by ingress, tile and egress
  typedef enum logic [2:0] {
    st_idle     = 3'd0,
    st_recv_ack = 3'd1,
    st_process  = 3'd2,
    st_send     = 3'd3,
    st_release  = 3'd4
  } tile_state_e;

  // in a response, dest_x/dest_y carry the source tile
  typedef struct packed {
    mesh_op_e   op;
    x_cord_t    dest_x;
    y_cord_t    dest_y;
    mem_addr_t  addr;
    mesh_data_t data;
  } mesh_pkt_s;

  // forward half of a link; ack runs back as its own bit
  typedef struct packed {
    logic      req;
    mesh_pkt_s pkt;
  } mesh_link_s;

endpackage

// File: hdl/mesh_params.svh
// mesh size, coordinate width, scratch depth and data width macros
`ifndef MESH_PARAMS_SVH
`define MESH_PARAMS_SVH

// tile columns and rows
`define MESH_X 2
`define MESH_Y 2

// global coordinate width, same for x and y
`define MESH_CORD_W 4

// scratch words per tile
`define MESH_MEM_WORDS 4

// data word width
`define MESH_DATA_W 16

`endif
